//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMemSys
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard source/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/memSys_checker.sv
module memSysChecker (
    input logic         clk,
    input logic         rst,
    input logic         rdy,
    input logic         ioFull,
    input logic         fetchReq,
    input logic         dataReq,
    input logic         fetchDone,
    input logic         dataDone,
    input logic         memBusy,
    input logic         ramWrite,
    input memPkg::byteT ramWdata
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // no byte access while stalled
    noWriteInStall: assert property (@(posedge clk) disable iff (rst)
        ramWrite |-> (rdy && !ioFull))
        else begin
            failCount = failCount + 1;
            $error("ramWrite was high in a stalled cycle");
        end

    wdataIdleZero: assert property (@(posedge clk) disable iff (rst)
        !ramWrite |-> (ramWdata == 8'h00))
        else begin
            failCount = failCount + 1;
            $error("ramWdata was not zero outside a write");
        end

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else begin
            failCount = failCount + 1;
            $error("fetchDone stayed high for more than one cycle");
        end

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else begin
            failCount = failCount + 1;
            $error("dataDone stayed high for more than one cycle");
        end

    busyAfterAccept: assert property (@(posedge clk) disable iff (rst)
        (fetchReq || dataReq) |=> memBusy)
        else begin
            failCount = failCount + 1;
            $error("memBusy did not rise after a request strobe");
        end

    // busy may only drop together with a done pulse
    busyHeldToDone: assert property (@(posedge clk) disable iff (rst)
        $fell(memBusy) |-> (fetchDone || dataDone))
        else begin
            failCount = failCount + 1;
            $error("memBusy fell without a done pulse");
        end

    resetQuiet: assert property (@(posedge clk)
        $fell(rst) |-> (!fetchDone && !dataDone && !ramWrite && !memBusy))
        else begin
            failCount = failCount + 1;
            $error("outputs not quiet in the cycle after reset");
        end

endmodule

bind memSys memSysChecker chk (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .ioFull    (ioFull),
    .fetchReq  (fetchReq),
    .dataReq   (dataReq),
    .fetchDone (fetchDone),
    .dataDone  (dataDone),
    .memBusy   (memBusy),
    .ramWrite  (ramWrite),
    .ramWdata  (ramWdata)
);

//--- bench/tbMemSys.sv
`include "mem_consts.svh"

module tbMemSys;
    timeunit 1ns;
    timeprecision 1ps;
    import memPkg::*;

    localparam int StallRequests = 40;
    // 4 fetches, 18 load/store/read-back, 3 paired strobes, up to 2 per stall round
    localparam int NumRequests = 28 + 2 * StallRequests;
    localparam int WatchdogNs = NumRequests * 20 * 100;

    logic clk = 1'b0;
    logic rst;
    logic rdy;
    logic ioFull;
    logic fetchReq;
    logic dataReq;
    logic dataStore;
    addrT fetchAddr;
    addrT dataAddr;
    lenT  dataLen;
    wordT dataWdata;
    byteT ramRdata;
    logic fetchDone;
    logic dataDone;
    logic memBusy;
    logic ramWrite;
    wordT fetchInst;
    wordT dataRdata;
    addrT ramAddr;
    byteT ramWdata;

    byteT   ram [0:255];
    byteT   shadow [0:255];
    addrT   wrAddrQ [$];
    byteT   wrDataQ [$];
    integer seed = 32'h327dff68;
    integer stallSeed = 32'h327dff68;
    logic   stallOn = 1'b0;

    memSys dut_i (.*);

    always #50 clk = ~clk;

    // byte RAM, read data one cycle behind the address
    always @(posedge clk) begin
        ramRdata <= ram[ramAddr[7:0]];
        if (ramWrite) begin
            ram[ramAddr[7:0]] <= ramWdata;
            wrAddrQ.push_back(ramAddr);
            wrDataQ.push_back(ramWdata);
        end
    end

    always @(posedge clk) begin
        if (stallOn) begin
            rdy    <= ($random(stallSeed) & 3) != 0;
            ioFull <= ($random(stallSeed) & 3) == 0;
        end else begin
            rdy    <= 1'b1;
            ioFull <= 1'b0;
        end
    end

    task automatic stopRun();
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
        stopRun();
    endtask

    task automatic reportProblem(string what);
        $display("ERROR: %s", what);
        stopRun();
    endtask

    always @(negedge clk) begin
        if (dut_i.chk.failCount != 0) begin
            reportProblem("a protocol assertion in the checker failed");
        end
    end

    initial begin
        #(WatchdogNs);
        reportProblem("watchdog expired before all requests completed");
    end

    // little endian bytes from the shadow copy, zero-extended
    function automatic wordT expectWord(addrT a, int n);
        wordT w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = shadow[8'(a + addrT'(i))];
        end
        return w;
    endfunction

    function automatic lenT pickLen(logic [1:0] r);
        return (r == 2'd0) ? lenT'(1) : (r == 2'd1) ? lenT'(2) : lenT'(4);
    endfunction

    task automatic checkData(logic store, int n, addrT a, wordT wd, int lat, logic checkLat);
        if (store) begin
            assert (wrAddrQ.size() == n)
                else reportMismatch("store write count", wrAddrQ.size(), n);
            for (int i = 0; i < n; i++) begin
                assert (wrAddrQ[i] == a + addrT'(i))
                    else reportMismatch("ramAddr", wrAddrQ[i], a + addrT'(i));
                assert (wrDataQ[i] == wd[8*i +: 8])
                    else reportMismatch("ramWdata", 32'(wrDataQ[i]), 32'(wd[8*i +: 8]));
                shadow[8'(a + addrT'(i))] = wd[8*i +: 8];
            end
            if (checkLat) begin
                assert (lat == n + 1) else reportMismatch("dataDone latency", lat, n + 1);
            end
        end else begin
            assert (wrAddrQ.size() == 0) else reportProblem("ramWrite rose during a load");
            assert (dataRdata == expectWord(a, n))
                else reportMismatch("dataRdata", dataRdata, expectWord(a, n));
            if (checkLat) begin
                assert (lat == n + 2) else reportMismatch("dataDone latency", lat, n + 2);
            end
        end
    endtask

    task automatic checkFetch(addrT a, int lat, logic checkLat);
        wordT want;
        want = expectWord(a, `MEM_FETCH_LEN);
        assert (fetchInst == want) else reportMismatch("fetchInst", fetchInst, want);
        if (checkLat) begin
            assert (lat == `MEM_FETCH_LEN + 2)
                else reportMismatch("fetchDone latency", lat, `MEM_FETCH_LEN + 2);
        end
    endtask

    // strobe one or both requesters, then wait for every done pulse
    task automatic runReq(logic doFetch, addrT fa, logic doData, logic store, lenT n,
                          addrT da, wordT wd, logic checkLat);
        int   lat;
        logic dataSeen;
        logic fetchSeen;
        wrAddrQ.delete();
        wrDataQ.delete();
        @(posedge clk);
        fetchReq  <= doFetch;
        fetchAddr <= fa;
        dataReq   <= doData;
        dataStore <= store;
        dataLen   <= n;
        dataAddr  <= da;
        dataWdata <= wd;
        @(posedge clk);
        fetchReq <= 1'b0;
        dataReq  <= 1'b0;
        lat = 0;
        dataSeen = !doData;
        fetchSeen = !doFetch;
        while (!(dataSeen && fetchSeen)) begin
            @(negedge clk);
            if (dataDone) begin
                dataSeen = 1'b1;
                checkData(store, int'(n), da, wd, lat, checkLat);
            end
            if (fetchDone) begin
                assert (dataSeen) else reportProblem("fetchDone came before dataDone");
                fetchSeen = 1'b1;
                checkFetch(fa, lat, checkLat && !doData);
            end
            lat++;
        end
    endtask

    initial begin
        logic [31:0] r;
        wordT        wd;
        lenT         n;
        addrT        a;
        rst       <= 1'b1;
        rdy       <= 1'b1;
        ioFull    <= 1'b0;
        fetchReq  <= 1'b0;
        dataReq   <= 1'b0;
        dataStore <= 1'b0;
        fetchAddr <= '0;
        dataAddr  <= '0;
        dataLen   <= '0;
        dataWdata <= '0;
        ramRdata  <= '0;
        for (int i = 0; i < 256; i++) begin
            ram[i] <= 8'(i * 7 + 'h13);
            shadow[i] = 8'(i * 7 + 'h13);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            runReq(1'b1, addrT'(r[7:0]), 1'b0, 1'b0, lenT'(1), '0, '0, 1'b1);
        end

        // load, store, then read the stored bytes back
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            wd = $random(seed);
            n = pickLen(2'(i % 3));
            a = addrT'(r[7:0]);
            runReq(1'b0, '0, 1'b1, 1'b0, n, a, '0, 1'b1);
            runReq(1'b0, '0, 1'b1, 1'b1, n, a, wd, 1'b1);
            runReq(1'b0, '0, 1'b1, 1'b0, n, a, '0, 1'b1);
        end

        // fetch and data strobe in the same cycle
        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            wd = $random(seed);
            runReq(1'b1, addrT'(r[7:0]), 1'b1, i == 1, pickLen(2'(i)),
                   addrT'(r[15:8]), wd, 1'b1);
        end

        stallOn = 1'b1;
        for (int i = 0; i < StallRequests; i++) begin
            r = $random(seed);
            wd = $random(seed);
            runReq(r[0], addrT'(r[15:8]), !r[0] || r[1], r[2], pickLen(r[4:3]),
                   addrT'(r[23:16]), wd, 1'b0);
        end
        stallOn = 1'b0;

        if (dut_i.chk.failCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            reportProblem("a protocol assertion in the checker failed");
        end
    end

endmodule

//--- filelist.f
+incdir+source
source/memPkg.sv
source/memIfs.sv
source/memReqDecode.sv
source/memByteEngine.sv
source/memResultAssembler.sv
source/memSys.sv
bench/memSys_checker.sv
bench/tbMemSys.sv

//--- source/memByteEngine.sv
module memByteEngine (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         ioFull,
    memReqIf.slave       req,
    memByteIf.master     byteBus,
    output memPkg::addrT ramAddr,
    output logic         ramWrite,
    output memPkg::byteT ramWdata
);
    import memPkg::*;

    engStateT state;
    reqKindT  kindR;
    addrT     baseR;
    lenT      lenR;
    wordT     wdataR;
    idxT      idx;
    idxT      lastIdx;
    logic     stall;
    logic     issuing;
    logic     isStore;
    logic     atLast;
    logic     storeEnd;
    logic     capReg;
    idxT      capIdx;
    logic     capLast;
    logic     captureOut;
    logic     lastOut;

    assign stall   = !rdy || ioFull;
    assign isStore = (kindR == kindStore);
    assign lastIdx = idxT'(lenR - lenT'(1));
    assign atLast  = (idx == lastIdx);

    // one byte access per non-stalled issue cycle
    assign issuing  = (state == engIssue) && !stall;
    assign storeEnd = issuing && isStore && atLast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= engIdle;
        end else begin
            case (state)
                engIdle: begin
                    if (req.start && !stall) begin
                        state <= engIssue;
                    end
                end
                engIssue: begin
                    if (issuing && atLast) begin
                        // reads still have the final byte in flight
                        state <= isStore ? engIdle : engDrain;
                    end
                end
                engDrain: begin
                    state <= engIdle;
                end
                default: begin
                    state <= engIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == engIdle && req.start && !stall) begin
            kindR  <= req.kind;
            baseR  <= req.addr;
            lenR   <= req.len;
            wdataR <= req.wdata;
            idx    <= '0;
        end else if (issuing && !atLast) begin
            idx <= idx + idxT'(1);
        end
    end

    // read data shows up one cycle behind its address
    always_ff @(posedge clk) begin
        if (rst) begin
            capReg <= 1'b0;
        end else begin
            capReg <= issuing && !isStore;
        end
    end

    always_ff @(posedge clk) begin
        capIdx  <= idx;
        capLast <= atLast;
    end

    assign captureOut = capReg || storeEnd;
    assign lastOut    = capReg ? capLast : storeEnd;

    assign byteBus.capture = captureOut;
    assign byteBus.kind    = kindR;
    assign byteBus.idx     = capIdx;
    assign byteBus.last    = lastOut;
    assign byteBus.len     = lenR;

    assign req.done = captureOut && lastOut;

    assign ramAddr  = baseR + addrT'(idx);
    assign ramWrite = issuing && isStore;
    assign ramWdata = ramWrite ? wdataR[8*idx +: 8] : '0;

endmodule

//--- source/memIfs.sv
// decode stage to byte engine
interface memReqIf;
    import memPkg::*;

    logic    start;
    reqKindT kind;
    addrT    addr;
    lenT     len;
    wordT    wdata;
    logic    done;

    modport master (
        output start, kind, addr, len, wdata,
        input  done
    );

    modport slave (
        input  start, kind, addr, len, wdata,
        output done
    );
endinterface

// byte engine to result stage
interface memByteIf;
    import memPkg::*;

    logic    capture;
    reqKindT kind;
    idxT     idx;
    logic    last;
    lenT     len;

    modport master (
        output capture, kind, idx, last, len
    );

    modport slave (
        input  capture, kind, idx, last, len
    );
endinterface

//--- source/memPkg.sv
`include "mem_consts.svh"

package memPkg;

    typedef logic [`MEM_ADDR_W-1:0] addrT;
    typedef logic [8*`MEM_WORD_BYTES-1:0] wordT;
    typedef logic [7:0] byteT;

    // legal lengths are 1, 2 and 4
    typedef logic [$clog2(`MEM_WORD_BYTES):0] lenT;
    typedef logic [$clog2(`MEM_WORD_BYTES)-1:0] idxT;

    typedef enum logic [1:0] {
        kindFetch,
        kindLoad,
        kindStore
    } reqKindT;

    // byte engine states
    typedef enum logic [1:0] {
        engIdle,
        engIssue,
        engDrain
    } engStateT;

endpackage

//--- source/memReqDecode.sv
`include "mem_consts.svh"

module memReqDecode (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         ioFull,
    input  logic         fetchReq,
    input  memPkg::addrT fetchAddr,
    input  logic         dataReq,
    input  logic         dataStore,
    input  memPkg::lenT  dataLen,
    input  memPkg::addrT dataAddr,
    input  memPkg::wordT dataWdata,
    output logic         memBusy,
    memReqIf.master      req
);
    import memPkg::*;

    logic    stall;
    logic    busy;
    logic    startQ;
    reqKindT kindQ;
    addrT    addrQ;
    lenT     lenQ;
    wordT    wdataQ;
    logic    pendFetch;
    addrT    pendAddr;
    logic    acceptData;
    logic    acceptFetch;
    logic    launchPend;

    assign stall = !rdy || ioFull;

    // data wins when both strobe together
    assign acceptData  = !busy && dataReq;
    assign acceptFetch = !busy && fetchReq && !dataReq;
    assign launchPend  = busy && req.done && pendFetch;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            startQ    <= 1'b0;
            pendFetch <= 1'b0;
        end else begin
            // start stays up through stalls until the engine can take it
            if (acceptData || acceptFetch || launchPend) begin
                startQ <= 1'b1;
            end else if (!stall) begin
                startQ <= 1'b0;
            end

            if (acceptData || acceptFetch) begin
                busy <= 1'b1;
            end else if (req.done && !pendFetch) begin
                busy <= 1'b0;
            end

            if (acceptData && fetchReq) begin
                pendFetch <= 1'b1;
            end else if (launchPend) begin
                pendFetch <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acceptData) begin
            kindQ  <= dataStore ? kindStore : kindLoad;
            addrQ  <= dataAddr;
            lenQ   <= dataLen;
            wdataQ <= dataWdata;
        end else if (acceptFetch || launchPend) begin
            kindQ <= kindFetch;
            addrQ <= acceptFetch ? fetchAddr : pendAddr;
            lenQ  <= lenT'(`MEM_FETCH_LEN);
        end

        // fetch held back behind a data request
        if (acceptData && fetchReq) begin
            pendAddr <= fetchAddr;
        end
    end

    assign req.start = startQ;
    assign req.kind  = kindQ;
    assign req.addr  = addrQ;
    assign req.len   = lenQ;
    assign req.wdata = wdataQ;

    assign memBusy = busy;

endmodule

//--- source/memResultAssembler.sv
module memResultAssembler (
    input  logic         clk,
    input  logic         rst,
    memByteIf.slave      byteBus,
    input  memPkg::byteT ramRdata,
    output logic         fetchDone,
    output logic         dataDone,
    output memPkg::wordT fetchInst,
    output memPkg::wordT dataRdata
);
    import memPkg::*;

    wordT collect;
    wordT merged;
    wordT extended;
    logic isRead;
    logic finish;

    assign isRead = (byteBus.kind != kindStore);
    assign finish = byteBus.capture && byteBus.last;

    // lane fill for every read byte
    always_ff @(posedge clk) begin
        if (byteBus.capture && isRead) begin
            collect[8*byteBus.idx +: 8] <= ramRdata;
        end
    end

    // final byte comes straight off the RAM bus
    always_comb begin
        merged = collect;
        merged[8*byteBus.idx +: 8] = ramRdata;
    end

    // zero-extend to the access length
    always_comb begin
        case (byteBus.len)
            lenT'(1): begin
                extended = wordT'(merged[7:0]);
            end
            lenT'(2): begin
                extended = wordT'(merged[15:0]);
            end
            default: begin
                extended = merged;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            fetchDone <= finish && (byteBus.kind == kindFetch);
            dataDone  <= finish && (byteBus.kind != kindFetch);
        end
    end

    // results held until the next completion of their kind
    always_ff @(posedge clk) begin
        if (finish && byteBus.kind == kindFetch) begin
            fetchInst <= extended;
        end
        if (finish && byteBus.kind == kindLoad) begin
            dataRdata <= extended;
        end
    end

endmodule

//--- source/memSys.sv
module memSys (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         ioFull,

    // instruction fetch
    input  logic         fetchReq,
    input  memPkg::addrT fetchAddr,
    output logic         fetchDone,
    output memPkg::wordT fetchInst,

    // load/store unit
    input  logic         dataReq,
    input  logic         dataStore,
    input  memPkg::lenT  dataLen,
    input  memPkg::addrT dataAddr,
    input  memPkg::wordT dataWdata,
    output logic         dataDone,
    output memPkg::wordT dataRdata,
    output logic         memBusy,

    // byte RAM
    input  memPkg::byteT ramRdata,
    output memPkg::addrT ramAddr,
    output logic         ramWrite,
    output memPkg::byteT ramWdata
);

    memReqIf  reqBus ();
    memByteIf byteBus ();

    memReqDecode decode (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .dataReq   (dataReq),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .memBusy   (memBusy),
        .req       (reqBus.master)
    );

    memByteEngine engine (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .ioFull   (ioFull),
        .req      (reqBus.slave),
        .byteBus  (byteBus.master),
        .ramAddr  (ramAddr),
        .ramWrite (ramWrite),
        .ramWdata (ramWdata)
    );

    memResultAssembler result (
        .clk       (clk),
        .rst       (rst),
        .byteBus   (byteBus.slave),
        .ramRdata  (ramRdata),
        .fetchDone (fetchDone),
        .dataDone  (dataDone),
        .fetchInst (fetchInst),
        .dataRdata (dataRdata)
    );

endmodule

//--- source/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address width of the core
`define MEM_ADDR_W 32

// bytes in one instruction or data word
`define MEM_WORD_BYTES 4

// an instruction fetch always reads a full word
`define MEM_FETCH_LEN 4

`endif
